//--- run.sh
#!/usr/bin/env bash
# Build and run the VDP command engine testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_vdp_cmd -f vlog.f -o tb_vdp_cmd

./obj_dir/tb_vdp_cmd | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

//--- sim/tb_vdp_cmd.sv
`include "vdp_cmd_defines.svh"

module tb_vdp_cmd;
  timeunit 1ns;
  timeprecision 1ns;

  localparam int MEM_SIZE   = 1 << `VDP_ADDR_W;
  localparam int ACK_LIMIT  = 16;
  localparam int RISE_LIMIT = 16;
  localparam int FALL_LIMIT = 40000;

  // Clock, on the DUT port named reset
  logic                        reset;
  // Async reset, on the DUT port named clk
  logic                        clk;
  logic                        reg_wr_req;
  logic [`VDP_REG_NUM_W-1:0]   reg_num;
  logic [`VDP_DATA_W-1:0]      reg_data;
  logic                        reg_wr_ack;
  logic                        vram_rd_req;
  logic                        vram_rd_ack;
  logic                        vram_wr_req;
  logic                        vram_wr_ack;
  logic [`VDP_ADDR_W-1:0]      vram_addr;
  logic [`VDP_DATA_W-1:0]      vram_rd_data;
  logic [`VDP_DATA_W-1:0]      vram_wr_data;
  logic                        ce;
  logic [`VDP_DATA_W-1:0]      clr;
  logic [3:0]                  current_command;

  // Expected VRAM contents
  logic [`VDP_DATA_W-1:0] model_mem [0:MEM_SIZE-1];
  integer seed;
  int     test_errors;
  int     pass_count;
  int     fail_count;
  logic   timed_out;

  vdp_cmd_top vdp_cmd_top_inst (
    .reset(reset), .clk(clk),
    .reg_wr_req(reg_wr_req), .reg_num(reg_num), .reg_data(reg_data),
    .vram_rd_ack(vram_rd_ack), .vram_rd_data(vram_rd_data), .vram_wr_ack(vram_wr_ack),
    .reg_wr_ack(reg_wr_ack), .vram_rd_req(vram_rd_req), .vram_wr_req(vram_wr_req),
    .vram_addr(vram_addr), .vram_wr_data(vram_wr_data),
    .ce(ce), .clr(clr), .current_command(current_command)
  );

  vram_model vram_model_inst (
    .reset(reset), .clk(clk),
    .rd_req(vram_rd_req), .wr_req(vram_wr_req),
    .addr(vram_addr), .wr_data(vram_wr_data),
    .rd_ack(vram_rd_ack), .wr_ack(vram_wr_ack), .rd_data(vram_rd_data)
  );

  initial begin
    reset = 1'b0;
    forever #50 reset = ~reset;
  end

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // Pixel rule of the logical operations
  function automatic logic [3:0] logic_result(input logic [2:0] op, input logic transp,
                                               input logic [3:0] src, input logic [3:0] dst);
    if (transp && src == 4'h0) return dst;
    case (op)
      vdp_cmd_pkg::IMP: return src;
      vdp_cmd_pkg::AND: return src & dst;
      vdp_cmd_pkg::OR:  return src | dst;
      vdp_cmd_pkg::XOR: return src ^ dst;
      vdp_cmd_pkg::NOT: return ~src;
      default:          return dst;
    endcase
  endfunction

  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    int n;
    if (timed_out) return;
    @(posedge reset);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    n = 0;
    @(negedge reset);
    while (reg_wr_ack != reg_wr_req && n < ACK_LIMIT) begin
      @(negedge reset);
      n++;
    end
    if (reg_wr_ack != reg_wr_req) begin
      $display("timeout: write to register %0d was never acknowledged", num);
      timed_out = 1'b1;
      test_errors++;
    end
  endtask

  task automatic load_regs(input logic [9:0] sx, input logic [9:0] sy,
                           input logic [9:0] dx, input logic [9:0] dy,
                           input logic [9:0] nx, input logic [9:0] ny,
                           input logic [7:0] color, input logic [7:0] arg);
    write_reg(`VDP_REG_SX_L, sx[7:0]);
    write_reg(`VDP_REG_SX_H, {6'b000000, sx[9:8]});
    write_reg(`VDP_REG_SY_L, sy[7:0]);
    write_reg(`VDP_REG_SY_H, {6'b000000, sy[9:8]});
    write_reg(`VDP_REG_DX_L, dx[7:0]);
    write_reg(`VDP_REG_DX_H, {6'b000000, dx[9:8]});
    write_reg(`VDP_REG_DY_L, dy[7:0]);
    write_reg(`VDP_REG_DY_H, {6'b000000, dy[9:8]});
    write_reg(`VDP_REG_NX_L, nx[7:0]);
    write_reg(`VDP_REG_NX_H, {6'b000000, nx[9:8]});
    write_reg(`VDP_REG_NY_L, ny[7:0]);
    write_reg(`VDP_REG_NY_H, {6'b000000, ny[9:8]});
    write_reg(`VDP_REG_CLR, color);
    write_reg(`VDP_REG_ARG, arg);
  endtask

  // Start by CMR write, then ce high and low again
  task automatic run_command(input string name, input logic [7:0] cmr);
    int n;
    write_reg(`VDP_REG_CMR, cmr);
    if (timed_out) return;
    // Opcode field of CMR shows on the command output
    if (current_command !== cmr[7:4]) begin
      $display("mismatch %s: current_command expected %h, actual %h",
               name, cmr[7:4], current_command);
      test_errors++;
    end
    n = 0;
    @(negedge reset);
    while (!ce && n < RISE_LIMIT) begin
      @(negedge reset);
      n++;
    end
    if (!ce) begin
      $display("timeout: ce never rose after command %02h was written", cmr);
      timed_out = 1'b1;
      test_errors++;
      return;
    end
    n = 0;
    while (ce && n < FALL_LIMIT) begin
      @(negedge reset);
      n++;
    end
    if (ce) begin
      $display("timeout: command %02h never finished, ce stayed high", cmr);
      timed_out = 1'b1;
      test_errors++;
    end
  endtask

  task automatic model_pixel(input logic [9:0] x, input logic [9:0] y, input logic [3:0] src,
                             input logic [2:0] op, input logic transp);
    logic [16:0] a;
    logic [7:0]  b;
    a = {y, x[7:1]};
    b = model_mem[a];
    // Odd X is the low nibble
    if (x[0]) b[3:0] = logic_result(op, transp, src, b[3:0]);
    else b[7:4] = logic_result(op, transp, src, b[7:4]);
    model_mem[a] = b;
  endtask

  // Rectangle walk with right and top clipping
  task automatic model_rect(input logic byte_mode, input logic [9:0] dx, input logic [9:0] dy,
                            input logic [9:0] nx, input logic [9:0] ny, input logic dix,
                            input logic diy, input logic [7:0] color, input logic [2:0] op,
                            input logic transp);
    logic [9:0] x;
    logic [9:0] y;
    logic [9:0] x_left;
    logic [9:0] y_left;
    logic [9:0] x_step;
    logic       done;
    x_step = byte_mode ? 10'd2 : 10'd1;
    if (dix) x_step = 10'd0 - x_step;
    y      = dy;
    y_left = ny;
    done   = 1'b0;
    while (!done) begin
      x      = dx;
      x_left = byte_mode ? (nx >> 1) : nx;
      do begin
        if (byte_mode) model_mem[{y, x[7:1]}] = color;
        else model_pixel(x, y, color[3:0], op, transp);
        x      = x + x_step;
        x_left = x_left - 10'd1;
      end while (x_left != 10'd0 && !x[8]);
      if (y_left == 10'd1 || (diy && y == 10'd0)) begin
        done = 1'b1;
      end else begin
        y      = diy ? y - 10'd1 : y + 10'd1;
        y_left = y_left - 10'd1;
      end
    end
  endtask

  task automatic compare_vram(input string name);
    logic [16:0] a;
    for (int i = 0; i < MEM_SIZE; i++) begin
      a = 17'(i);
      if (model_mem[a] !== vram_model_inst.mem[a]) begin
        // First few shown, the rest only counted
        if (test_errors < 8) begin
          $display("mismatch %s: vram[%05h] expected %02h, actual %02h",
                   name, a, model_mem[a], vram_model_inst.mem[a]);
        end
        test_errors++;
      end
    end
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: pass", name);
      pass_count++;
    end else begin
      $display("test %s: fail, %0d errors", name, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  task automatic test_hmmv;
    logic [9:0] dx;
    logic [9:0] dy;
    logic [9:0] nx;
    logic [9:0] ny;
    logic       dix;
    logic       diy;
    logic [7:0] color;
    for (int i = 0; i < 12; i++) begin
      dx = 10'(rand_below(128) * 2);
      // Right border cases
      if (i % 3 == 0) dx = 10'(240 + rand_below(8) * 2);
      dy = 10'(rand_below(1024));
      // Top border cases
      if (i % 3 == 1) dy = 10'(rand_below(4));
      nx    = 10'(2 + rand_below(16) * 2);
      ny    = 10'(1 + rand_below(16));
      dix   = 1'(rand_below(2));
      diy   = 1'(rand_below(2));
      color = 8'(rand_below(256));
      load_regs(10'd0, 10'd0, dx, dy, nx, ny, color, {4'b0000, diy, dix, 2'b00});
      run_command("hmmv_fill", {vdp_cmd_pkg::HMMV, 4'(rand_below(16))});
      model_rect(1'b1, dx, dy, nx, ny, dix, diy, color, 3'd0, 1'b0);
    end
    compare_vram("hmmv_fill");
  endtask

  task automatic test_lmmv;
    logic [9:0] dx;
    logic [9:0] dy;
    logic [9:0] nx;
    logic [9:0] ny;
    logic       dix;
    logic       diy;
    logic       transp;
    logic [2:0] op;
    logic [7:0] color;
    for (int i = 0; i < 12; i++) begin
      dx = 10'(rand_below(256));
      if (i % 3 == 0) dx = 10'(248 + rand_below(8));
      dy = 10'(rand_below(1024));
      if (i % 3 == 1) dy = 10'(rand_below(4));
      nx     = 10'(1 + rand_below(32));
      ny     = 10'(1 + rand_below(16));
      dix    = 1'(rand_below(2));
      diy    = 1'(rand_below(2));
      transp = 1'(rand_below(2));
      op     = 3'(rand_below(8));
      color  = 8'(rand_below(256));
      // Colour 0 now and then, for the transparent case
      if (rand_below(4) == 0) color[3:0] = 4'h0;
      load_regs(10'd0, 10'd0, dx, dy, nx, ny, color, {4'b0000, diy, dix, 2'b00});
      run_command("lmmv_fill", {vdp_cmd_pkg::LMMV, transp, op});
      model_rect(1'b0, dx, dy, nx, ny, dix, diy, color, op, transp);
    end
    compare_vram("lmmv_fill");
  endtask

  task automatic test_pset;
    logic [9:0] dx;
    logic [9:0] dy;
    logic       transp;
    logic [2:0] op;
    logic [7:0] color;
    for (int i = 0; i < 16; i++) begin
      dx     = 10'(rand_below(256));
      dy     = 10'(rand_below(1024));
      transp = 1'(rand_below(2));
      op     = 3'(rand_below(8));
      color  = 8'(rand_below(256));
      if (rand_below(4) == 0) color[3:0] = 4'h0;
      // Counts and directions play no part in PSET
      load_regs(10'd0, 10'd0, dx, dy, 10'(rand_below(64)), 10'(rand_below(64)), color,
                8'(rand_below(256)));
      run_command("pset", {vdp_cmd_pkg::PSET, transp, op});
      model_pixel(dx, dy, color[3:0], op, transp);
    end
    compare_vram("pset");
  endtask

  task automatic test_point;
    logic [9:0] sx;
    logic [9:0] sy;
    logic [7:0] b;
    logic [7:0] expected;
    for (int i = 0; i < 16; i++) begin
      sx = 10'(rand_below(256));
      sy = 10'(rand_below(1024));
      load_regs(sx, sy, 10'(rand_below(256)), 10'(rand_below(1024)), 10'd1, 10'd1,
                8'(rand_below(256)), 8'd0);
      run_command("point", {vdp_cmd_pkg::POINT, 4'(rand_below(16))});
      b = model_mem[{sy, sx[7:1]}];
      expected = {4'h0, sx[0] ? b[3:0] : b[7:4]};
      if (!timed_out && clr !== expected) begin
        $display("mismatch point: clr at (%0d,%0d) expected %02h, actual %02h",
                 sx, sy, expected, clr);
        test_errors++;
      end
    end
    compare_vram("point");
  endtask

  task automatic test_stop;
    logic [3:0] op;
    for (int i = 0; i < 8; i++) begin
      // STOP itself or any opcode outside the four commands
      op = 4'(rand_below(16));
      while (op == vdp_cmd_pkg::POINT || op == vdp_cmd_pkg::PSET ||
             op == vdp_cmd_pkg::LMMV || op == vdp_cmd_pkg::HMMV) begin
        op = 4'(rand_below(16));
      end
      load_regs(10'(rand_below(256)), 10'(rand_below(1024)), 10'(rand_below(256)),
                10'(rand_below(1024)), 10'(1 + rand_below(32)), 10'(1 + rand_below(16)),
                8'(rand_below(256)), 8'(rand_below(256)));
      run_command("stop", {op, 4'(rand_below(16))});
    end
    compare_vram("stop");
  endtask

  initial begin
    seed        = 32'hf164;
    clk         = 1'b1;
    reg_wr_req  = 1'b0;
    reg_num     = '0;
    reg_data    = '0;
    timed_out   = 1'b0;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    repeat (3) @(posedge reset);
    clk <= 1'b0;
    @(negedge reset);

    // VRAM model fills itself on reset
    for (int i = 0; i < MEM_SIZE; i++) begin
      model_mem[17'(i)] = vram_model_inst.mem[17'(i)];
    end

    if ({ce, vram_rd_req, vram_wr_req, reg_wr_ack, clr} !== 12'h000) begin
      $display("mismatch reset: ce,rd_req,wr_req,reg_wr_ack,clr expected %03h, actual %03h",
               12'h000, {ce, vram_rd_req, vram_wr_req, reg_wr_ack, clr});
      test_errors++;
    end
    finish_test("reset");

    test_hmmv();
    finish_test("hmmv_fill");
    test_lmmv();
    finish_test("lmmv_fill");
    test_pset();
    finish_test("pset");
    test_point();
    finish_test("point");
    test_stop();
    finish_test("stop");

    $display("tests passed %0d, failed %0d", pass_count, fail_count);
    if (fail_count == 0 && !timed_out) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- sim/vram_model.sv
`include "vdp_cmd_defines.svh"

module vram_model (
  input  logic                    reset,
  input  logic                    clk,
  input  logic                    rd_req,
  input  logic                    wr_req,
  input  logic [`VDP_ADDR_W-1:0]  addr,
  input  logic [`VDP_DATA_W-1:0]  wr_data,
  output logic                    rd_ack,
  output logic                    wr_ack,
  output logic [`VDP_DATA_W-1:0]  rd_data
);
  timeunit 1ns;
  timeprecision 1ns;

  localparam int MEM_SIZE = 1 << `VDP_ADDR_W;

  // 128 KiB of byte storage
  logic [`VDP_DATA_W-1:0] mem [0:MEM_SIZE-1];
  integer                 seed = 32'hf164;
  logic [31:0]            rnd;
  logic [`VDP_ADDR_W-1:0] fill_addr;
  logic [2:0]             delay;
  logic                   pending;

  // Clock on the reset port, reset on the clk port
  always @(posedge reset or posedge clk) begin
    if (clk) begin
      // Random contents, a new byte per address
      fill_addr = '0;
      for (int i = 0; i < MEM_SIZE; i++) begin
        rnd = $random(seed);
        mem[fill_addr] = rnd[7:0];
        fill_addr = fill_addr + 1'b1;
      end
      rd_ack  <= 1'b0;
      wr_ack  <= 1'b0;
      rd_data <= '0;
      delay   <= '0;
      pending <= 1'b0;
    end else if (!pending) begin
      // New toggle seen, pick 0 to 5 extra cycles
      if (rd_req != rd_ack || wr_req != wr_ack) begin
        rnd = $random(seed);
        delay   <= 3'(rnd % 32'd6);
        pending <= 1'b1;
      end
    end else if (delay != 3'd0) begin
      delay <= delay - 3'd1;
    end else begin
      pending <= 1'b0;
      if (rd_req != rd_ack) begin
        // Data valid in the same cycle as the ack
        rd_data <= mem[addr];
        rd_ack  <= rd_req;
      end else begin
        mem[addr] = wr_data;
        wr_ack <= wr_req;
      end
    end
  end

endmodule

//--- src/vdp_cmd_ctrl.sv
module vdp_cmd_ctrl (
  input  logic                  reset,
  input  logic                  clk,
  input  logic                  cmd_start,
  input  logic                  reg_hold,
  input  vdp_cmd_pkg::cmd_op_e  opcode,
  input  logic                  x_end,
  input  logic                  y_end,
  input  logic                  vram_rd_ack,
  input  logic                  vram_wr_ack,
  output logic                  ce,
  output logic                  vram_rd_req,
  output logic                  vram_wr_req,
  output logic                  walk_load,
  output logic                  walk_step_x,
  output logic                  walk_next_line,
  output logic                  addr_src_sel,
  output logic                  wdata_fill,
  output logic                  wdata_merge,
  output logic                  clr_load_point
);

  vdp_cmd_pkg::cmd_state_e state;
  vdp_cmd_pkg::cmd_state_e state_nxt;
  logic start_pend;
  logic first_pass;
  logic advance;
  logic rd_busy;
  logic wr_busy;
  logic rd_toggle;
  logic wr_toggle;
  logic ce_set;
  logic ce_clr;

  assign rd_busy = vram_rd_req != vram_rd_ack;
  assign wr_busy = vram_wr_req != vram_wr_ack;
  // Register writes and a new start both freeze the sequencer
  assign advance = !cmd_start && !reg_hold;
  // Source address held for the whole POINT read
  assign addr_src_sel = (state == vdp_cmd_pkg::RD_SRC) || (state == vdp_cmd_pkg::WAIT_RD_SRC);

  always_comb begin
    state_nxt      = state;
    walk_load      = 1'b0;
    walk_step_x    = 1'b0;
    walk_next_line = 1'b0;
    wdata_fill     = 1'b0;
    wdata_merge    = 1'b0;
    clr_load_point = 1'b0;
    rd_toggle      = 1'b0;
    wr_toggle      = 1'b0;
    ce_set         = 1'b0;
    ce_clr         = 1'b0;
    if (advance) begin
      case (state)
        vdp_cmd_pkg::IDLE: begin
          // Wait out any access left over from an aborted command
          if (start_pend && !rd_busy && !wr_busy) begin
            walk_load = 1'b1;
            ce_set    = 1'b1;
            state_nxt = vdp_cmd_pkg::CHK_LOOP;
          end
        end
        vdp_cmd_pkg::CHK_LOOP: begin
          if (!first_pass && x_end && y_end) begin
            state_nxt = vdp_cmd_pkg::EXEC_END;
          end else begin
            walk_next_line = !first_pass && x_end;
            case (opcode)
              vdp_cmd_pkg::HMMV: begin
                wdata_fill = 1'b1;
                state_nxt  = vdp_cmd_pkg::WR;
              end
              vdp_cmd_pkg::LMMV, vdp_cmd_pkg::PSET: begin
                wdata_fill = 1'b1;
                state_nxt  = vdp_cmd_pkg::PRE_RD;
              end
              vdp_cmd_pkg::POINT: state_nxt = vdp_cmd_pkg::RD_SRC;
              default: state_nxt = vdp_cmd_pkg::EXEC_END;
            endcase
          end
        end
        vdp_cmd_pkg::RD_SRC: begin
          rd_toggle = 1'b1;
          state_nxt = vdp_cmd_pkg::WAIT_RD_SRC;
        end
        vdp_cmd_pkg::WAIT_RD_SRC: begin
          if (!rd_busy) begin
            clr_load_point = 1'b1;
            state_nxt      = vdp_cmd_pkg::EXEC_END;
          end
        end
        vdp_cmd_pkg::PRE_RD: begin
          rd_toggle = 1'b1;
          state_nxt = vdp_cmd_pkg::WAIT_PRE_RD;
        end
        vdp_cmd_pkg::WAIT_PRE_RD: begin
          if (!rd_busy) begin
            wdata_merge = 1'b1;
            state_nxt   = vdp_cmd_pkg::WR;
          end
        end
        vdp_cmd_pkg::WR: begin
          wr_toggle = 1'b1;
          state_nxt = vdp_cmd_pkg::WAIT_WR;
        end
        vdp_cmd_pkg::WAIT_WR: begin
          if (!wr_busy) begin
            // PSET is a single dot
            if (opcode == vdp_cmd_pkg::PSET) begin
              state_nxt = vdp_cmd_pkg::EXEC_END;
            end else begin
              walk_step_x = 1'b1;
              state_nxt   = vdp_cmd_pkg::CHK_LOOP;
            end
          end
        end
        default: begin
          ce_clr    = 1'b1;
          state_nxt = vdp_cmd_pkg::IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      state       <= vdp_cmd_pkg::IDLE;
      ce          <= 1'b0;
      vram_rd_req <= 1'b0;
      vram_wr_req <= 1'b0;
      start_pend  <= 1'b0;
      first_pass  <= 1'b0;
    end else begin
      // New command aborts whatever runs
      if (cmd_start) begin
        state      <= vdp_cmd_pkg::IDLE;
        start_pend <= 1'b1;
      end else begin
        state <= state_nxt;
        if (walk_load) begin
          start_pend <= 1'b0;
        end
      end
      if (ce_set) begin
        ce <= 1'b1;
      end else if (ce_clr) begin
        ce <= 1'b0;
      end
      if (rd_toggle) begin
        vram_rd_req <= ~vram_rd_ack;
      end
      if (wr_toggle) begin
        vram_wr_req <= ~vram_wr_ack;
      end
      // Loop end is not checked on the entry pass
      if (walk_load) begin
        first_pass <= 1'b1;
      end else if (advance && state == vdp_cmd_pkg::CHK_LOOP) begin
        first_pass <= 1'b0;
      end
    end
  end

  a_rd_req_held: assert property (@(posedge reset) disable iff (clk)
    rd_busy |=> $stable(vram_rd_req));
  a_wr_req_held: assert property (@(posedge reset) disable iff (clk)
    wr_busy |=> $stable(vram_wr_req));
  a_one_access: assert property (@(posedge reset) disable iff (clk)
    !(rd_busy && wr_busy));

endmodule

//--- src/vdp_cmd_defines.svh
`ifndef VDP_CMD_DEFINES_SVH
`define VDP_CMD_DEFINES_SVH

// Datapath widths
`define VDP_COORD_W     10
`define VDP_ADDR_W      17
`define VDP_DATA_W      8
`define VDP_PIX_W       4
`define VDP_REG_NUM_W   4

// Command register numbers
`define VDP_REG_SX_L    4'd0
`define VDP_REG_SX_H    4'd1
`define VDP_REG_SY_L    4'd2
`define VDP_REG_SY_H    4'd3
`define VDP_REG_DX_L    4'd4
`define VDP_REG_DX_H    4'd5
`define VDP_REG_DY_L    4'd6
`define VDP_REG_DY_H    4'd7
`define VDP_REG_NX_L    4'd8
`define VDP_REG_NX_H    4'd9
`define VDP_REG_NY_L    4'd10
`define VDP_REG_NY_H    4'd11
`define VDP_REG_CLR     4'd12
`define VDP_REG_ARG     4'd13
`define VDP_REG_CMR     4'd14

// Set once the cursor leaves columns 0..255
`define VDP_X_LIMIT_BIT 8

`endif

//--- src/vdp_cmd_pixel.sv
`include "vdp_cmd_defines.svh"

module vdp_cmd_pixel (
  input  logic                        reset,
  input  logic                        clk,
  input  logic [`VDP_DATA_W-1:0]      vram_rd_data,
  input  logic                        x_low,
  input  logic [`VDP_DATA_W-1:0]      clr,
  input  logic                        transp,
  input  vdp_cmd_pkg::logic_op_e      log_op,
  input  logic                        wdata_fill,
  input  logic                        wdata_merge,
  output logic [`VDP_DATA_W-1:0]      vram_wr_data,
  output logic [`VDP_PIX_W-1:0]       point_pix
);

  logic [`VDP_PIX_W-1:0]  src_pix;
  logic [`VDP_PIX_W-1:0]  dst_pix;
  logic [`VDP_PIX_W-1:0]  res_pix;
  logic [`VDP_DATA_W-1:0] merged;

  // High nibble is the even pixel
  assign dst_pix   = x_low ? vram_rd_data[3:0] : vram_rd_data[7:4];
  assign point_pix = dst_pix;
  assign src_pix   = clr[`VDP_PIX_W-1:0];

  always_comb begin
    // Transparent colour 0 leaves the screen alone
    if (transp && src_pix == '0) begin
      res_pix = dst_pix;
    end else begin
      case (log_op)
        vdp_cmd_pkg::IMP: res_pix = src_pix;
        vdp_cmd_pkg::AND: res_pix = src_pix & dst_pix;
        vdp_cmd_pkg::OR:  res_pix = src_pix | dst_pix;
        vdp_cmd_pkg::XOR: res_pix = src_pix ^ dst_pix;
        vdp_cmd_pkg::NOT: res_pix = ~src_pix;
        default:          res_pix = dst_pix;
      endcase
    end
  end

  // Neighbour nibble comes back unchanged
  assign merged = x_low ? {vram_rd_data[7:4], res_pix} : {res_pix, vram_rd_data[3:0]};

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      vram_wr_data <= '0;
    end else if (wdata_fill) begin
      // Byte fill takes CLR as is
      vram_wr_data <= clr;
    end else if (wdata_merge) begin
      vram_wr_data <= merged;
    end
  end

endmodule

//--- src/vdp_cmd_pkg.sv
package vdp_cmd_pkg;

  // Command sequencer states
  typedef enum logic [3:0] {
    IDLE,
    CHK_LOOP,
    RD_SRC,
    WAIT_RD_SRC,
    PRE_RD,
    WAIT_PRE_RD,
    WR,
    WAIT_WR,
    EXEC_END
  } cmd_state_e;

  // CMR bits 7:4, only the supported commands
  typedef enum logic [3:0] {
    STOP  = 4'b0000,
    POINT = 4'b0100,
    PSET  = 4'b0101,
    LMMV  = 4'b1000,
    HMMV  = 4'b1100
  } cmd_op_e;

  // CMR bits 2:0
  typedef enum logic [2:0] {
    IMP = 3'b000,
    AND = 3'b001,
    OR  = 3'b010,
    XOR = 3'b011,
    NOT = 3'b100
  } logic_op_e;

endpackage

//--- src/vdp_cmd_regs.sv
`include "vdp_cmd_defines.svh"

module vdp_cmd_regs (
  input  logic                        reset,
  input  logic                        clk,
  input  logic                        reg_wr_req,
  input  logic [`VDP_REG_NUM_W-1:0]   reg_num,
  input  logic [`VDP_DATA_W-1:0]      reg_data,
  input  logic                        ce,
  input  logic                        clr_load_point,
  input  logic [`VDP_PIX_W-1:0]       point_pix,
  output logic                        reg_wr_ack,
  output logic                        reg_hold,
  output logic                        cmd_start,
  output logic [`VDP_COORD_W-1:0]     sx,
  output logic [`VDP_COORD_W-1:0]     sy,
  output logic [`VDP_COORD_W-1:0]     dx,
  output logic [`VDP_COORD_W-1:0]     dy,
  output logic [`VDP_COORD_W-1:0]     nx,
  output logic [`VDP_COORD_W-1:0]     ny,
  output logic [`VDP_DATA_W-1:0]      clr,
  output logic                        dix,
  output logic                        diy,
  output vdp_cmd_pkg::cmd_op_e        opcode,
  output logic                        transp,
  output vdp_cmd_pkg::logic_op_e      log_op
);

  logic [`VDP_DATA_W-1:0] cmr;

  // Toggle pending until the ack catches up
  assign reg_hold = reg_wr_req != reg_wr_ack;

  assign opcode = vdp_cmd_pkg::cmd_op_e'(cmr[7:4]);
  assign transp = cmr[3];
  assign log_op = vdp_cmd_pkg::logic_op_e'(cmr[2:0]);

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      reg_wr_ack <= 1'b0;
      cmd_start  <= 1'b0;
      sx         <= '0;
      sy         <= '0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr        <= '0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmr        <= '0;
    end else begin
      // One-cycle pulse after a CMR write lands
      cmd_start <= reg_hold && (reg_num == `VDP_REG_CMR);
      if (reg_hold) begin
        reg_wr_ack <= reg_wr_req;
        case (reg_num)
          `VDP_REG_SX_L: sx[7:0] <= reg_data;
          `VDP_REG_SX_H: sx[9:8] <= reg_data[1:0];
          `VDP_REG_SY_L: sy[7:0] <= reg_data;
          `VDP_REG_SY_H: sy[9:8] <= reg_data[1:0];
          `VDP_REG_DX_L: dx[7:0] <= reg_data;
          `VDP_REG_DX_H: dx[9:8] <= reg_data[1:0];
          `VDP_REG_DY_L: dy[7:0] <= reg_data;
          `VDP_REG_DY_H: dy[9:8] <= reg_data[1:0];
          `VDP_REG_NX_L: nx[7:0] <= reg_data;
          `VDP_REG_NX_H: nx[9:8] <= reg_data[1:0];
          `VDP_REG_NY_L: ny[7:0] <= reg_data;
          `VDP_REG_NY_H: ny[9:8] <= reg_data[1:0];
          // Only a pixel is kept while a command runs
          `VDP_REG_CLR: clr <= ce ? {4'b0000, reg_data[`VDP_PIX_W-1:0]} : reg_data;
          `VDP_REG_ARG: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          `VDP_REG_CMR: cmr <= reg_data;
          default: ;
        endcase
      end else if (clr_load_point) begin
        // POINT result
        clr <= {4'b0000, point_pix};
      end
    end
  end

  // Host handshake cannot retrigger a start back to back
  a_start_single: assert property (@(posedge reset) disable iff (clk)
    cmd_start |=> !cmd_start);

endmodule

//--- src/vdp_cmd_top.sv
`include "vdp_cmd_defines.svh"

module vdp_cmd_top (
  input  logic                        reset,
  input  logic                        clk,
  input  logic                        reg_wr_req,
  input  logic [`VDP_REG_NUM_W-1:0]   reg_num,
  input  logic [`VDP_DATA_W-1:0]      reg_data,
  input  logic                        vram_rd_ack,
  input  logic [`VDP_DATA_W-1:0]      vram_rd_data,
  input  logic                        vram_wr_ack,
  output logic                        reg_wr_ack,
  output logic                        vram_rd_req,
  output logic                        vram_wr_req,
  output logic [`VDP_ADDR_W-1:0]      vram_addr,
  output logic [`VDP_DATA_W-1:0]      vram_wr_data,
  output logic                        ce,
  output logic [`VDP_DATA_W-1:0]      clr,
  output logic [3:0]                  current_command
);

  logic [`VDP_COORD_W-1:0] sx;
  logic [`VDP_COORD_W-1:0] sy;
  logic [`VDP_COORD_W-1:0] dx;
  logic [`VDP_COORD_W-1:0] dy;
  logic [`VDP_COORD_W-1:0] nx;
  logic [`VDP_COORD_W-1:0] ny;
  logic [`VDP_PIX_W-1:0]   point_pix;
  vdp_cmd_pkg::cmd_op_e    opcode;
  vdp_cmd_pkg::logic_op_e  log_op;
  logic reg_hold;
  logic cmd_start;
  logic dix;
  logic diy;
  logic transp;
  logic x_end;
  logic y_end;
  logic x_low;
  logic walk_load;
  logic walk_step_x;
  logic walk_next_line;
  logic addr_src_sel;
  logic wdata_fill;
  logic wdata_merge;
  logic clr_load_point;

  assign current_command = opcode;

  vdp_cmd_regs vdp_cmd_regs_inst (
    .reset(reset), .clk(clk),
    .reg_wr_req(reg_wr_req), .reg_num(reg_num), .reg_data(reg_data),
    .ce(ce), .clr_load_point(clr_load_point), .point_pix(point_pix),
    .reg_wr_ack(reg_wr_ack), .reg_hold(reg_hold), .cmd_start(cmd_start),
    .sx(sx), .sy(sy), .dx(dx), .dy(dy), .nx(nx), .ny(ny),
    .clr(clr), .dix(dix), .diy(diy),
    .opcode(opcode), .transp(transp), .log_op(log_op)
  );

  vdp_cmd_ctrl vdp_cmd_ctrl_inst (
    .reset(reset), .clk(clk),
    .cmd_start(cmd_start), .reg_hold(reg_hold), .opcode(opcode),
    .x_end(x_end), .y_end(y_end),
    .vram_rd_ack(vram_rd_ack), .vram_wr_ack(vram_wr_ack),
    .ce(ce), .vram_rd_req(vram_rd_req), .vram_wr_req(vram_wr_req),
    .walk_load(walk_load), .walk_step_x(walk_step_x),
    .walk_next_line(walk_next_line), .addr_src_sel(addr_src_sel),
    .wdata_fill(wdata_fill), .wdata_merge(wdata_merge),
    .clr_load_point(clr_load_point)
  );

  vdp_cmd_walker vdp_cmd_walker_inst (
    .reset(reset), .clk(clk),
    .walk_load(walk_load), .walk_step_x(walk_step_x),
    .walk_next_line(walk_next_line), .addr_src_sel(addr_src_sel),
    .opcode(opcode),
    .sx(sx), .sy(sy), .dx(dx), .dy(dy), .nx(nx), .ny(ny),
    .dix(dix), .diy(diy),
    .x_end(x_end), .y_end(y_end), .vram_addr(vram_addr), .x_low(x_low)
  );

  vdp_cmd_pixel vdp_cmd_pixel_inst (
    .reset(reset), .clk(clk),
    .vram_rd_data(vram_rd_data), .x_low(x_low), .clr(clr),
    .transp(transp), .log_op(log_op),
    .wdata_fill(wdata_fill), .wdata_merge(wdata_merge),
    .vram_wr_data(vram_wr_data), .point_pix(point_pix)
  );

endmodule

//--- src/vdp_cmd_walker.sv
`include "vdp_cmd_defines.svh"

module vdp_cmd_walker (
  input  logic                     reset,
  input  logic                     clk,
  input  logic                     walk_load,
  input  logic                     walk_step_x,
  input  logic                     walk_next_line,
  input  logic                     addr_src_sel,
  input  vdp_cmd_pkg::cmd_op_e     opcode,
  input  logic [`VDP_COORD_W-1:0]  sx,
  input  logic [`VDP_COORD_W-1:0]  sy,
  input  logic [`VDP_COORD_W-1:0]  dx,
  input  logic [`VDP_COORD_W-1:0]  dy,
  input  logic [`VDP_COORD_W-1:0]  nx,
  input  logic [`VDP_COORD_W-1:0]  ny,
  input  logic                     dix,
  input  logic                     diy,
  output logic                     x_end,
  output logic                     y_end,
  output logic [`VDP_ADDR_W-1:0]   vram_addr,
  output logic                     x_low
);

  logic [`VDP_COORD_W-1:0] x_cur;
  logic [`VDP_COORD_W-1:0] x_cnt;
  logic [`VDP_COORD_W-1:0] y_cur;
  logic [`VDP_COORD_W-1:0] y_cnt;
  logic [`VDP_COORD_W-1:0] nx_count;
  logic [`VDP_COORD_W-1:0] x_delta;
  logic [`VDP_COORD_W-1:0] x_step;
  logic [`VDP_COORD_W-1:0] y_step;
  logic [`VDP_COORD_W-1:0] x_sel;
  logic [`VDP_COORD_W-1:0] y_sel;
  logic                    is_byte;

  // HMMV moves a whole byte, two pixels at a time
  assign is_byte  = opcode == vdp_cmd_pkg::HMMV;
  assign nx_count = is_byte ? {1'b0, nx[`VDP_COORD_W-1:1]} : nx;
  assign x_delta  = is_byte ? `VDP_COORD_W'd2 : `VDP_COORD_W'd1;
  assign x_step   = dix ? ('0 - x_delta) : x_delta;
  assign y_step   = diy ? '1 : `VDP_COORD_W'd1;

  // Right border, or wrapped below column 0
  assign x_end = (x_cnt == '0) || x_cur[`VDP_X_LIMIT_BIT];
  // Last line, or top border going up
  assign y_end = (y_cnt == `VDP_COORD_W'd1) || (diy && y_cur == '0);

  // Source point for POINT, else the cursor
  assign x_sel     = addr_src_sel ? sx : x_cur;
  assign y_sel     = addr_src_sel ? sy : y_cur;
  assign vram_addr = {y_sel, x_sel[`VDP_X_LIMIT_BIT-1:1]};
  assign x_low     = x_sel[0];

  always_ff @(posedge reset or posedge clk) begin
    if (clk) begin
      x_cur <= '0;
      x_cnt <= '0;
      y_cur <= '0;
      y_cnt <= '0;
    end else if (walk_load) begin
      x_cur <= dx;
      x_cnt <= nx_count;
      y_cur <= dy;
      y_cnt <= ny;
    end else if (walk_next_line) begin
      // Back to DX on the next line
      x_cur <= dx;
      x_cnt <= nx_count;
      y_cur <= y_cur + y_step;
      y_cnt <= y_cnt - `VDP_COORD_W'd1;
    end else if (walk_step_x) begin
      x_cur <= x_cur + x_step;
      x_cnt <= x_cnt - `VDP_COORD_W'd1;
    end
  end

endmodule

//--- vlog.f
+incdir+src
src/vdp_cmd_pkg.sv
src/vdp_cmd_regs.sv
src/vdp_cmd_ctrl.sv
src/vdp_cmd_walker.sv
src/vdp_cmd_pixel.sv
src/vdp_cmd_top.sv
sim/vram_model.sv
sim/tb_vdp_cmd.sv
